/* Makefile */
VERILATOR  := verilator
TOP        := mesh_noc_tb
FILE_LIST  := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
src/noc_cfg_pkg.sv
src/noc_flit_pkg.sv
src/noc_link_if.sv
src/input_buffer.sv
src/xy_route_arbiter.sv
src/mesh_router.sv
src/mesh_noc.sv
sim/mesh_noc_properties.sv
sim/mesh_noc_tb.sv

/* sim/mesh_noc_properties.sv */
module mesh_noc_properties #(
  parameter int rows = noc_cfg_pkg::default_rows,
  parameter int cols = noc_cfg_pkg::default_cols,
  parameter int buffer_depth = noc_cfg_pkg::default_buffer_depth
) (
  input logic                [rows*cols-1:0] local_in_credit,
  input logic                                clk,
  input logic                                reset,
  input logic                [rows*cols-1:0] local_out_valid,
  input noc_cfg_pkg::coord_t                 local_out_dest_row [rows*cols],
  input noc_cfg_pkg::coord_t                 local_out_dest_col [rows*cols],
  input logic                [rows*cols-1:0] local_out_credit
);
  import noc_cfg_pkg::*;

  // quiet while in reset and one cycle beyond
  assert property (@(posedge clk)
    (reset || $past(reset)) |=> (local_out_valid == '0 && local_in_credit == '0))
    else $error("local valid or credit active around reset");

  for (genvar n = 0; n < rows * cols; n++)
  begin : node_g
    // flits handed to the sink whose credit has not come back
    int unreturned;

    always_ff @(posedge clk)
    begin
      if (reset)
        unreturned <= 0;
      else
        unreturned <= unreturned + int'(local_out_valid[n]) - int'(local_out_credit[n]);
    end

    assert property (@(posedge clk) disable iff (reset)
      local_out_valid[n] |-> (local_out_dest_row[n] == coord_t'(n / cols) &&
                              local_out_dest_col[n] == coord_t'(n % cols)))
      else $error("node %0d delivered a flit addressed elsewhere", n);

    assert property (@(posedge clk) disable iff (reset) unreturned <= buffer_depth)
      else $error("node %0d has more than %0d flits without credit", n, buffer_depth);
  end

endmodule

bind mesh_noc mesh_noc_properties #(
  .rows(rows),
  .cols(cols),
  .buffer_depth(buffer_depth)
) mesh_noc_properties_inst (
  .local_in_credit(local_in_credit),
  .clk(clk),
  .reset(reset),
  .local_out_valid(local_out_valid),
  .local_out_dest_row(local_out_dest_row),
  .local_out_dest_col(local_out_dest_col),
  .local_out_credit(local_out_credit)
);

/* sim/mesh_noc_tb.sv */
module mesh_noc_tb;
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int rows = 3;
  localparam int cols = 3;
  localparam int buffer_depth = 4;
  localparam int num_nodes = rows * cols;
  localparam int flits_per_source = 20;
  localparam int total_flits = num_nodes * flits_per_source;
  localparam int timeout_cycles = total_flits * 40;
  localparam int withhold_node = 4;
  localparam int withhold_start = 20;
  localparam int withhold_cycles = 30;

  logic clk;
  logic reset;
  logic [num_nodes-1:0] local_in_valid;
  coord_t local_in_dest_row [num_nodes];
  coord_t local_in_dest_col [num_nodes];
  payload_t local_in_payload [num_nodes];
  logic [num_nodes-1:0] local_in_credit;
  logic [num_nodes-1:0] local_out_valid;
  coord_t local_out_dest_row [num_nodes];
  coord_t local_out_dest_col [num_nodes];
  payload_t local_out_payload [num_nodes];
  logic [num_nodes-1:0] local_out_credit;

  // expected payloads, one queue per source and destination pair
  payload_t expected_q [num_nodes*num_nodes][$];
  // cycle at which each sink hands a credit back
  int due_q [num_nodes][$];
  int source_credits [num_nodes];
  int sent [num_nodes];
  int outstanding [num_nodes];
  int injected;
  int delivered;
  int self_delivered;
  int cycle_count = 0;

  mesh_noc #(
    .rows(rows),
    .cols(cols),
    .buffer_depth(buffer_depth)
  ) mesh_noc_inst (
    .clk(clk),
    .reset(reset),
    .local_in_valid(local_in_valid),
    .local_in_dest_row(local_in_dest_row),
    .local_in_dest_col(local_in_dest_col),
    .local_in_payload(local_in_payload),
    .local_in_credit(local_in_credit),
    .local_out_valid(local_out_valid),
    .local_out_dest_row(local_out_dest_row),
    .local_out_dest_col(local_out_dest_col),
    .local_out_payload(local_out_payload),
    .local_out_credit(local_out_credit)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // **************************************************
  // failure reporting and compares
  // **************************************************

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_payload(input string name, input payload_t got, input payload_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout after %0d cycles, %0d of %0d flits delivered",
               cycle_count, delivered, injected);
      abort_run();
    end
  end

  // **************************************************
  // sources, sinks and scoreboard
  // **************************************************

  task automatic check_reset_quiet();
    for (int n = 0; n < num_nodes; n++)
    begin
      compare_flag($sformatf("local_out_valid[%0d]", n), local_out_valid[n], 1'b0);
      compare_flag($sformatf("local_in_credit[%0d]", n), local_in_credit[n], 1'b0);
    end
  endtask

  task automatic collect_deliveries();
    int src;
    int due;
    payload_t exp;
    for (int d = 0; d < num_nodes; d++)
    begin
      if (local_in_credit[d])
      begin
        source_credits[d]++;
        if (source_credits[d] > buffer_depth)
        begin
          $display("source %0d received a credit for a flit it never sent", d);
          abort_run();
        end
      end
      if (local_out_valid[d])
      begin
        compare_coord($sformatf("local_out_dest_row[%0d]", d), local_out_dest_row[d],
                      coord_t'(d / cols));
        compare_coord($sformatf("local_out_dest_col[%0d]", d), local_out_dest_col[d],
                      coord_t'(d % cols));
        // top nibble names the source node
        src = int'(local_out_payload[d][payload_width-1:4]);
        if (src >= num_nodes)
        begin
          $display("node %0d delivered a flit from unknown source %0d", d, src);
          abort_run();
        end
        if (expected_q[src * num_nodes + d].size() == 0)
        begin
          $display("node %0d delivered an extra flit from source %0d", d, src);
          abort_run();
        end
        exp = expected_q[src * num_nodes + d].pop_front();
        compare_payload($sformatf("local_out_payload[%0d]", d), local_out_payload[d], exp);
        delivered++;
        if (src == d)
          self_delivered++;
        outstanding[d]++;
        if (outstanding[d] > buffer_depth)
        begin
          $display("sink %0d holds more than %0d flits without credit", d, buffer_depth);
          abort_run();
        end
        due = cycle_count + int'($urandom_range(0, 3));
        if (due_q[d].size() > 0 && due < due_q[d][$])
          due = due_q[d][$];
        due_q[d].push_back(due);
      end
    end
  endtask

  task automatic drive_sink_credits();
    bit withhold;
    for (int d = 0; d < num_nodes; d++)
    begin
      withhold = (d == withhold_node) && (cycle_count >= withhold_start) &&
                 (cycle_count < withhold_start + withhold_cycles);
      local_out_credit[d] = 1'b0;
      if (!withhold && due_q[d].size() > 0 && due_q[d][0] <= cycle_count)
      begin
        void'(due_q[d].pop_front());
        local_out_credit[d] = 1'b1;
        outstanding[d]--;
      end
    end
  endtask

  task automatic drive_sources();
    int d;
    payload_t pl;
    for (int n = 0; n < num_nodes; n++)
    begin
      local_in_valid[n] = 1'b0;
      if (sent[n] < flits_per_source && source_credits[n] > 0 && $urandom_range(0, 1) == 1)
      begin
        d = int'($urandom_range(0, num_nodes - 1));
        pl = payload_t'({4'(n), 4'(sent[n])});
        local_in_valid[n] = 1'b1;
        local_in_dest_row[n] = coord_t'(d / cols);
        local_in_dest_col[n] = coord_t'(d % cols);
        local_in_payload[n] = pl;
        expected_q[n * num_nodes + d].push_back(pl);
        source_credits[n]--;
        sent[n]++;
        injected++;
      end
    end
  endtask

  function automatic bit all_done();
    for (int n = 0; n < num_nodes; n++)
    begin
      if (sent[n] < flits_per_source)
        return 1'b0;
    end
    for (int q = 0; q < num_nodes * num_nodes; q++)
    begin
      if (expected_q[q].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // every source holds its full credit and every sink has answered
  function automatic bit credits_home();
    for (int n = 0; n < num_nodes; n++)
    begin
      if (source_credits[n] != buffer_depth || due_q[n].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  initial
  begin
    void'($urandom(55302));
    reset = 1'b1;
    local_in_valid = '0;
    local_out_credit = '0;
    injected = 0;
    delivered = 0;
    self_delivered = 0;
    for (int n = 0; n < num_nodes; n++)
    begin
      local_in_dest_row[n] = '0;
      local_in_dest_col[n] = '0;
      local_in_payload[n] = '0;
      source_credits[n] = buffer_depth;
      sent[n] = 0;
      outstanding[n] = 0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    check_reset_quiet();
    while (!all_done())
    begin
      collect_deliveries();
      drive_sink_credits();
      drive_sources();
      @(posedge clk);
      #1;
    end
    // drain the credit loops, still watching for stray flits
    collect_deliveries();
    while (!credits_home())
    begin
      drive_sink_credits();
      drive_sources();
      @(posedge clk);
      #1;
      collect_deliveries();
    end
    if (delivered != total_flits || delivered != injected || self_delivered == 0)
    begin
      $display("delivered %0d of %0d flits, %0d to their own node",
               delivered, injected, self_delivered);
      abort_run();
    end
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

/* src/input_buffer.sv */
module input_buffer #(
  parameter int buffer_depth = noc_cfg_pkg::default_buffer_depth
) (
  input  logic                   clk,
  input  logic                   reset,
  noc_link_if.rx                 in,
  input  logic                   pop,
  output logic                   head_valid,
  output noc_cfg_pkg::coord_t    head_dest_row,
  output noc_cfg_pkg::coord_t    head_dest_col,
  output noc_flit_pkg::payload_t head_payload
);
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int ptr_width = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;

  coord_t row_mem [buffer_depth];
  coord_t col_mem [buffer_depth];
  payload_t payload_mem [buffer_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [credit_width-1:0] count;
  logic credit_q;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(buffer_depth - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  // sender honours credits, so no full check on write
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end
    else
    begin
      if (in.valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      count    <= count + credit_width'(in.valid) - credit_width'(pop);
      credit_q <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in.valid)
    begin
      row_mem[wr_ptr]     <= in.dest_row;
      col_mem[wr_ptr]     <= in.dest_col;
      payload_mem[wr_ptr] <= in.payload;
    end
  end

  assign head_valid    = (count != '0);
  assign head_dest_row = row_mem[rd_ptr];
  assign head_dest_col = col_mem[rd_ptr];
  assign head_payload  = payload_mem[rd_ptr];

  // slot freed by a pop goes back upstream one cycle later
  assign in.credit = credit_q;

endmodule

/* src/mesh_noc.sv */
module mesh_noc #(
  parameter int rows = noc_cfg_pkg::default_rows,
  parameter int cols = noc_cfg_pkg::default_cols,
  parameter int buffer_depth = noc_cfg_pkg::default_buffer_depth
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [rows*cols-1:0]   local_in_valid,
  input  noc_cfg_pkg::coord_t    local_in_dest_row [rows*cols],
  input  noc_cfg_pkg::coord_t    local_in_dest_col [rows*cols],
  input  noc_flit_pkg::payload_t local_in_payload [rows*cols],
  output logic [rows*cols-1:0]   local_in_credit,
  output logic [rows*cols-1:0]   local_out_valid,
  output noc_cfg_pkg::coord_t    local_out_dest_row [rows*cols],
  output noc_cfg_pkg::coord_t    local_out_dest_col [rows*cols],
  output noc_flit_pkg::payload_t local_out_payload [rows*cols],
  input  logic [rows*cols-1:0]   local_out_credit
);
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  // router outputs and credit returns, per node and port
  logic out_valid [rows*cols][num_ports];
  coord_t out_dest_row [rows*cols][num_ports];
  coord_t out_dest_col [rows*cols][num_ports];
  payload_t out_payload [rows*cols][num_ports];
  logic in_credit [rows*cols][num_ports];

  for (genvar r = 0; r < rows; r++)
  begin : row_g
    for (genvar c = 0; c < cols; c++)
    begin : col_g
      localparam int n = r * cols + c;

      noc_link_if in_link [num_ports] ();
      noc_link_if out_link [num_ports] ();

      mesh_router #(
        .row(coord_t'(r)),
        .col(coord_t'(c)),
        .buffer_depth(buffer_depth)
      ) router_inst (
        .clk(clk),
        .reset(reset),
        .in_link(in_link),
        .out_link(out_link)
      );

      for (genvar p = 0; p < num_ports; p++)
      begin : port_g
        // neighbour position and the port that faces back at us
        localparam int nr = (p == int'(port_north)) ? r - 1 :
                            (p == int'(port_south)) ? r + 1 : r;
        localparam int nc = (p == int'(port_west)) ? c - 1 :
                            (p == int'(port_east)) ? c + 1 : c;
        localparam int m = nr * cols + nc;
        localparam int opp = ((p + 1) % 4) + 1;

        assign out_valid[n][p]    = out_link[p].valid;
        assign out_dest_row[n][p] = out_link[p].dest_row;
        assign out_dest_col[n][p] = out_link[p].dest_col;
        assign out_payload[n][p]  = out_link[p].payload;
        assign in_credit[n][p]    = in_link[p].credit;

        if (p == int'(port_local))
        begin : local_g
          assign in_link[p].valid     = local_in_valid[n];
          assign in_link[p].dest_row  = local_in_dest_row[n];
          assign in_link[p].dest_col  = local_in_dest_col[n];
          assign in_link[p].payload   = local_in_payload[n];
          assign local_in_credit[n]   = in_link[p].credit;
          assign local_out_valid[n]    = out_link[p].valid;
          assign local_out_dest_row[n] = out_link[p].dest_row;
          assign local_out_dest_col[n] = out_link[p].dest_col;
          assign local_out_payload[n]  = out_link[p].payload;
          assign out_link[p].credit    = local_out_credit[n];
        end
        else if (nr >= 0 && nr < rows && nc >= 0 && nc < cols)
        begin : link_g
          assign in_link[p].valid    = out_valid[m][opp];
          assign in_link[p].dest_row = out_dest_row[m][opp];
          assign in_link[p].dest_col = out_dest_col[m][opp];
          assign in_link[p].payload  = out_payload[m][opp];
          assign out_link[p].credit  = in_credit[m][opp];
        end
        else
        begin : edge_g
          // outward edge, nothing arrives and nothing is sent
          assign in_link[p].valid    = 1'b0;
          assign in_link[p].dest_row = '0;
          assign in_link[p].dest_col = '0;
          assign in_link[p].payload  = '0;
          assign out_link[p].credit  = 1'b0;
        end
      end
    end
  end

endmodule

/* src/mesh_router.sv */
module mesh_router #(
  parameter noc_cfg_pkg::coord_t row = '0,
  parameter noc_cfg_pkg::coord_t col = '0,
  parameter int buffer_depth = noc_cfg_pkg::default_buffer_depth
) (
  input  logic   clk,
  input  logic   reset,
  noc_link_if.rx in_link  [noc_flit_pkg::num_ports],
  noc_link_if.tx out_link [noc_flit_pkg::num_ports]
);
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  logic [num_ports-1:0] head_valid;
  coord_t head_dest_row [num_ports];
  coord_t head_dest_col [num_ports];
  payload_t head_payload [num_ports];

  logic [num_ports-1:0] pop;
  logic [num_ports-1:0] out_ready;
  logic [num_ports-1:0] grant_valid;
  port_e grant [num_ports];

  xy_route_arbiter #(
    .row(row),
    .col(col)
  ) arbiter_inst (
    .clk(clk),
    .reset(reset),
    .head_valid(head_valid),
    .head_dest_row(head_dest_row),
    .head_dest_col(head_dest_col),
    .out_ready(out_ready),
    .grant(grant),
    .grant_valid(grant_valid)
  );

  // a granted head leaves its FIFO on the same edge it is registered
  always_comb
  begin
    pop = '0;
    for (int o = 0; o < num_ports; o++)
    begin
      if (grant_valid[o])
        pop[grant[o]] = 1'b1;
    end
  end

  for (genvar p = 0; p < num_ports; p++)
  begin : port_g
    logic valid_q;
    coord_t dest_row_q;
    coord_t dest_col_q;
    payload_t payload_q;
    logic [credit_width-1:0] credit_count;

    input_buffer #(
      .buffer_depth(buffer_depth)
    ) input_buffer_inst (
      .clk(clk),
      .reset(reset),
      .in(in_link[p]),
      .pop(pop[p]),
      .head_valid(head_valid[p]),
      .head_dest_row(head_dest_row[p]),
      .head_dest_col(head_dest_col[p]),
      .head_payload(head_payload[p])
    );

    // free slots downstream, less flits still in flight
    always_ff @(posedge clk)
    begin
      if (reset)
      begin
        valid_q      <= 1'b0;
        credit_count <= credit_width'(buffer_depth);
      end
      else
      begin
        valid_q      <= grant_valid[p];
        credit_count <= credit_count - credit_width'(grant_valid[p])
                        + credit_width'(out_link[p].credit);
      end
    end

    always_ff @(posedge clk)
    begin
      if (grant_valid[p])
      begin
        dest_row_q <= head_dest_row[grant[p]];
        dest_col_q <= head_dest_col[grant[p]];
        payload_q  <= head_payload[grant[p]];
      end
    end

    assign out_ready[p] = (credit_count != '0);

    assign out_link[p].valid    = valid_q;
    assign out_link[p].dest_row = dest_row_q;
    assign out_link[p].dest_col = dest_col_q;
    assign out_link[p].payload  = payload_q;
  end

endmodule

/* src/noc_cfg_pkg.sv */
package noc_cfg_pkg;

  // **************************************************
  // mesh geometry defaults
  // **************************************************

  localparam int default_rows = 3;
  localparam int default_cols = 3;

  // flits per input FIFO
  localparam int default_buffer_depth = 4;

  // **************************************************
  // derived widths
  // **************************************************

  // row or column index, up to an 8x8 grid
  localparam int coord_width = 3;

  // counter must reach the full buffer depth, not depth-1
  localparam int credit_width = $clog2(default_buffer_depth + 1);

  typedef logic [coord_width-1:0] coord_t;

endpackage

/* src/noc_flit_pkg.sv */
package noc_flit_pkg;

  // **************************************************
  // flit fields
  // **************************************************

  localparam int payload_width = 8;

  typedef logic [payload_width-1:0] payload_t;

  // **************************************************
  // router ports
  // **************************************************

  localparam int num_ports = 5;

  // opposite ports differ by two, wrapping over the four mesh directions
  typedef enum logic [2:0]
  {
    port_local = 3'd0,
    port_north = 3'd1,
    port_east  = 3'd2,
    port_south = 3'd3,
    port_west  = 3'd4
  } port_e;

endpackage

/* src/noc_link_if.sv */
interface noc_link_if;
  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  // single-flit packet, driven by the sender
  logic valid;
  coord_t dest_row;
  coord_t dest_col;
  payload_t payload;

  // one pulse per slot freed at the receiver
  logic credit;

  modport tx
  (
    output valid,
    output dest_row,
    output dest_col,
    output payload,
    input  credit
  );

  modport rx
  (
    input  valid,
    input  dest_row,
    input  dest_col,
    input  payload,
    output credit
  );

endinterface

/* src/xy_route_arbiter.sv */
module xy_route_arbiter #(
  parameter noc_cfg_pkg::coord_t row = '0,
  parameter noc_cfg_pkg::coord_t col = '0
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [noc_flit_pkg::num_ports-1:0]  head_valid,
  input  noc_cfg_pkg::coord_t                 head_dest_row [noc_flit_pkg::num_ports],
  input  noc_cfg_pkg::coord_t                 head_dest_col [noc_flit_pkg::num_ports],
  input  logic [noc_flit_pkg::num_ports-1:0]  out_ready,
  output noc_flit_pkg::port_e                 grant [noc_flit_pkg::num_ports],
  output logic [noc_flit_pkg::num_ports-1:0]  grant_valid
);
  import noc_flit_pkg::*;

  port_e req_port [num_ports];
  port_e last_winner [num_ports];

  // **************************************************
  // route computation, column first then row
  // **************************************************

  always_comb
  begin
    for (int i = 0; i < num_ports; i++)
    begin
      if (head_dest_col[i] > col)
        req_port[i] = port_east;
      else if (head_dest_col[i] < col)
        req_port[i] = port_west;
      else if (head_dest_row[i] > row)
        req_port[i] = port_south;
      else if (head_dest_row[i] < row)
        req_port[i] = port_north;
      else
        req_port[i] = port_local;
    end
  end

  // **************************************************
  // round-robin grant per output
  // **************************************************

  // each head requests one output only, so one grant per input at most
  always_comb
  begin
    int cand;
    cand = 0;
    for (int o = 0; o < num_ports; o++)
    begin
      grant[o]       = port_local;
      grant_valid[o] = 1'b0;
      if (out_ready[o])
      begin
        for (int k = 1; k <= num_ports; k++)
        begin
          cand = (int'(last_winner[o]) + k) % num_ports;
          if (!grant_valid[o] && head_valid[cand] && req_port[cand] == port_e'(o))
          begin
            grant_valid[o] = 1'b1;
            grant[o]       = port_e'(cand);
          end
        end
      end
    end
  end

  // starting from west puts local first after reset
  always_ff @(posedge clk)
  begin
    for (int o = 0; o < num_ports; o++)
    begin
      if (reset)
        last_winner[o] <= port_west;
      else if (grant_valid[o])
        last_winner[o] <= grant[o];
    end
  end

endmodule
